// File: agu_pkg.sv
package agu_pkg;

    // --------------------------------------------------
    // transform geometry
    // --------------------------------------------------
    localparam int log_n           = 6;
    localparam int n_points        = 1 << log_n;
    localparam int lanes           = 2;
    localparam int beats_per_stage = n_points / 2 / lanes;
    localparam int beat_w          = $clog2(beats_per_stage);
    localparam int stage_w         = 3;

    // 4 banks, row address is what is left of the index
    localparam int bank_w = 2;
    localparam int addr_w = log_n - bank_w;

    typedef logic [log_n-1:0]   idx_t;
    typedef logic [bank_w-1:0]  bank_t;
    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [stage_w-1:0] stage_t;

    // --------------------------------------------------
    // bank mapping
    // --------------------------------------------------

    // digit sum mod 4, so the two operands of a butterfly
    // always land in different banks
    function automatic bank_t bank_of(idx_t idx);
        bank_t sum;
        sum = '0;
        for (int d = 0; d < log_n / bank_w; d++) begin
            sum = sum + idx[d*bank_w +: bank_w];
        end
        return sum;
    endfunction

    function automatic addr_t addr_of(idx_t idx);
        idx_t row;
        row = idx >> bank_w;
        return addr_t'(row);
    endfunction

endpackage

// File: agu_order_if.sv
interface agu_order_if;

    import agu_pkg::*;

    logic   valid;
    logic   done;
    stage_t stage;
    // one index pair per lane
    idx_t   idx0 [lanes];
    idx_t   idx1 [lanes];

    modport gen (
        output valid,
        output done,
        output stage,
        output idx0,
        output idx1
    );

    modport xlat (
        input valid,
        input done,
        input stage,
        input idx0,
        input idx1
    );

endinterface

// File: butterfly_order_gen.sv
module butterfly_order_gen (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    agu_order_if.gen ord
);

    import agu_pkg::*;

    logic              busy;
    stage_t            stage_cnt;
    logic [beat_w-1:0] beat_cnt;
    logic              last_of_stage;
    logic              last_beat;

    idx_t half;
    idx_t low_mask;
    idx_t bfly     [lanes];
    idx_t nxt_idx0 [lanes];
    idx_t nxt_idx1 [lanes];

    // --------------------------------------------------
    // index pairs for the current beat
    // --------------------------------------------------

    always_comb begin
        half     = idx_t'(n_points >> (stage_cnt + 1));
        low_mask = half - idx_t'(1);
        for (int l = 0; l < lanes; l++) begin
            bfly[l] = idx_t'(beat_cnt * lanes + l);
            // open a zero bit at the position of half
            nxt_idx0[l] = ((bfly[l] & ~low_mask) << 1) | (bfly[l] & low_mask);
            nxt_idx1[l] = nxt_idx0[l] | half;
        end
    end

    assign last_of_stage = (beat_cnt == beat_w'(beats_per_stage - 1));
    assign last_beat     = last_of_stage && (stage_cnt == stage_t'(log_n - 1));

    // --------------------------------------------------
    // counters and control
    // --------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            stage_cnt <= '0;
            beat_cnt  <= '0;
            ord.valid <= 1'b0;
            ord.done  <= 1'b0;
            ord.stage <= '0;
        end else begin
            ord.valid <= busy;
            ord.done  <= busy && last_beat;
            if (busy) begin
                ord.stage <= stage_cnt;
                if (last_of_stage) begin
                    beat_cnt  <= '0;
                    stage_cnt <= stage_cnt + 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
                if (last_beat) begin
                    busy <= 1'b0;
                end
            end else if (start) begin
                busy      <= 1'b1;
                stage_cnt <= '0;
                beat_cnt  <= '0;
            end
        end
    end

    // indices, held between runs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < lanes; l++) begin
                ord.idx0[l] <= '0;
                ord.idx1[l] <= '0;
            end
        end else if (busy) begin
            for (int l = 0; l < lanes; l++) begin
                ord.idx0[l] <= nxt_idx0[l];
                ord.idx1[l] <= nxt_idx1[l];
            end
        end
    end

endmodule

// File: order_translate.sv
module order_translate (
    input  logic           clk,
    input  logic           rst,
    agu_order_if.xlat      ord,
    output logic           out_valid,
    output logic           done,
    output agu_pkg::stage_t stage,
    output agu_pkg::bank_t bn0 [agu_pkg::lanes],
    output agu_pkg::bank_t bn1 [agu_pkg::lanes],
    output agu_pkg::addr_t ma0 [agu_pkg::lanes],
    output agu_pkg::addr_t ma1 [agu_pkg::lanes]
);

    import agu_pkg::*;

    logic   valid_q;
    logic   done_q;
    stage_t stage_q;
    idx_t   idx0_q [lanes];
    idx_t   idx1_q [lanes];

    // --------------------------------------------------
    // input register
    // --------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
            stage_q <= '0;
        end else begin
            valid_q <= ord.valid;
            done_q  <= ord.done;
            stage_q <= ord.stage;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < lanes; l++) begin
                idx0_q[l] <= '0;
                idx1_q[l] <= '0;
            end
        end else begin
            for (int l = 0; l < lanes; l++) begin
                idx0_q[l] <= ord.idx0[l];
                idx1_q[l] <= ord.idx1[l];
            end
        end
    end

    // --------------------------------------------------
    // bank / row translation and output register
    // --------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            done      <= 1'b0;
            stage     <= '0;
        end else begin
            out_valid <= valid_q;
            done      <= done_q;
            stage     <= stage_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < lanes; l++) begin
                bn0[l] <= '0;
                bn1[l] <= '0;
                ma0[l] <= '0;
                ma1[l] <= '0;
            end
        end else begin
            for (int l = 0; l < lanes; l++) begin
                bn0[l] <= bank_of(idx0_q[l]);
                bn1[l] <= bank_of(idx1_q[l]);
                ma0[l] <= addr_of(idx0_q[l]);
                ma1[l] <= addr_of(idx1_q[l]);
            end
        end
    end

endmodule

// File: ntt_agu_top.sv
module ntt_agu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,

    output logic            out_valid,
    output logic            done,
    output agu_pkg::stage_t stage,

    // per lane operand banks and rows
    output agu_pkg::bank_t  bn0 [agu_pkg::lanes],
    output agu_pkg::bank_t  bn1 [agu_pkg::lanes],
    output agu_pkg::addr_t  ma0 [agu_pkg::lanes],
    output agu_pkg::addr_t  ma1 [agu_pkg::lanes]
);

    // --------------------------------------------------
    // generator to translator
    // --------------------------------------------------

    agu_order_if ord_if ();

    butterfly_order_gen gen_i (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .ord   (ord_if.gen)
    );

    // two cycles from index pair to bank/row
    order_translate xlat_i (
        .clk       (clk),
        .rst       (rst),
        .ord       (ord_if.xlat),
        .out_valid (out_valid),
        .done      (done),
        .stage     (stage),
        .bn0       (bn0),
        .bn1       (bn1),
        .ma0       (ma0),
        .ma1       (ma1)
    );

endmodule

// File: ntt_agu_assert.sv
module ntt_agu_assert (
    input logic            clk,
    input logic            rst,
    input logic            out_valid,
    input logic            done,
    input agu_pkg::stage_t stage,
    input agu_pkg::bank_t  bn0 [agu_pkg::lanes],
    input agu_pkg::bank_t  bn1 [agu_pkg::lanes]
);

    import agu_pkg::*;

    // --------------------------------------------------
    // control
    // --------------------------------------------------

    done_needs_valid: assert property (
        @(posedge clk) disable iff (rst) done |-> out_valid
    ) else $error("done high without out_valid");

    stage_in_range: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> (stage < stage_t'(log_n))
    ) else $error("stage %0d out of range", stage);

    // both operands of a butterfly in different banks
    for (genvar l = 0; l < lanes; l++) begin : g_lane
        banks_differ: assert property (
            @(posedge clk) disable iff (rst) out_valid |-> (bn0[l] != bn1[l])
        ) else $error("lane %0d operands share bank %0h", l, bn0[l]);
    end

endmodule

// File: tb_ntt_agu.sv
module tb_ntt_agu;

    import agu_pkg::*;

    localparam int reset_cycles = 10;
    localparam int total_beats  = log_n * beats_per_stage;
    localparam int num_runs     = 3;

    logic   clk;
    logic   rst;
    logic   start;
    logic   out_valid;
    logic   done;
    stage_t stage;
    bank_t  bn0 [lanes];
    bank_t  bn1 [lanes];
    addr_t  ma0 [lanes];
    addr_t  ma1 [lanes];

    logic [31:0] rand_state;
    int          runs_started;
    int          runs_done;
    int          beat_idx;

    ntt_agu_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .out_valid (out_valid),
        .done      (done),
        .stage     (stage),
        .bn0       (bn0),
        .bn1       (bn1),
        .ma0       (ma0),
        .ma1       (ma1)
    );

    bind ntt_agu_top ntt_agu_assert assert_i (
        .clk       (clk),
        .rst       (rst),
        .out_valid (out_valid),
        .done      (done),
        .stage     (stage),
        .bn0       (bn0),
        .bn1       (bn1)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {17'd0, rand_state[30:16]};
    endfunction

    // sum of the 2-bit digits, mod 4
    function automatic bank_t digit_sum(int i);
        return bank_t'(((i & 3) + ((i >> 2) & 3) + ((i >> 4) & 3)) % 4);
    endfunction

    // expected banks and rows for one lane of one beat
    function automatic void ref_lane(input int s, input int beat, input int lane,
                                     output bank_t b0, output bank_t b1,
                                     output addr_t a0, output addr_t a1);
        int half;
        int bfly;
        int i0;
        int i1;
        half = n_points >> (s + 1);
        bfly = beat * lanes + lane;
        i0   = (bfly / half) * 2 * half + bfly % half;
        i1   = i0 + half;
        b0   = digit_sum(i0);
        b1   = digit_sum(i1);
        a0   = addr_t'(i0 >> bank_w);
        a1   = addr_t'(i1 >> bank_w);
    endfunction

    task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(string what);
        $display("ERROR: %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic wait_first_beat();
        int edges;
        edges = 0;
        @(negedge clk);
        while (!out_valid) begin
            @(posedge clk);
            edges++;
            if (edges > 10) abort_run("no output beat arrived after start");
            @(negedge clk);
        end
        check_equal("first beat latency", edges, 3);
    endtask

    task automatic wait_run_end(int target);
        int cycles;
        cycles = 0;
        while (runs_done < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > 200) abort_run("run did not finish with a done beat");
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    initial begin
        int gap;
        rand_state   = 32'd61;
        runs_started = 0;
        rst          = 1'b1;
        start        = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < num_runs; r++) begin
            gap = 2 + next_rand() % 8;
            // idle, nothing may come out
            repeat (gap) begin
                @(negedge clk);
                check_equal("out_valid", out_valid, 0);
                check_equal("done", done, 0);
            end
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            runs_started++;
            wait_first_beat();
            // extra starts while busy are ignored
            repeat (80) begin
                @(posedge clk);
                start <= (next_rand() % 3 == 0);
            end
            @(posedge clk);
            start <= 1'b0;
            wait_run_end(r + 1);
        end
        repeat (8) begin
            @(negedge clk);
            check_equal("out_valid", out_valid, 0);
        end
        if (runs_done == num_runs && beat_idx == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "wrong number of completed runs");
        end
    end

    // --------------------------------------------------
    // comparison, one beat per falling edge
    // --------------------------------------------------

    initial begin
        runs_done = 0;
        beat_idx  = 0;
    end

    always @(negedge clk) begin : compare_beats
        bank_t exp_b0;
        bank_t exp_b1;
        addr_t exp_a0;
        addr_t exp_a1;
        int    s;
        if (!rst) begin
            if (out_valid) begin
                if (runs_started == runs_done) abort_run("output beat without a start");
                s = beat_idx / beats_per_stage;
                check_equal("stage", stage, s);
                check_equal("done", done, beat_idx == total_beats - 1);
                for (int l = 0; l < lanes; l++) begin
                    ref_lane(s, beat_idx % beats_per_stage, l, exp_b0, exp_b1, exp_a0, exp_a1);
                    check_equal($sformatf("bn0[%0d]", l), bn0[l], exp_b0);
                    check_equal($sformatf("bn1[%0d]", l), bn1[l], exp_b1);
                    check_equal($sformatf("ma0[%0d]", l), ma0[l], exp_a0);
                    check_equal($sformatf("ma1[%0d]", l), ma1[l], exp_a1);
                end
                if (beat_idx == total_beats - 1) begin
                    beat_idx = 0;
                    runs_done++;
                end else begin
                    beat_idx++;
                end
            end else begin
                if (beat_idx != 0) abort_run("out_valid dropped before the last beat");
                check_equal("done", done, 0);
            end
        end
    end

endmodule

// File: vlog.f
agu_pkg.sv
agu_order_if.sv
butterfly_order_gen.sv
order_translate.sv
ntt_agu_top.sv
ntt_agu_assert.sv
tb_ntt_agu.sv

// File: Bender.yml
package:
  name: ntt_agu

sources:
  - agu_pkg.sv
  - agu_order_if.sv
  - butterfly_order_gen.sv
  - order_translate.sv
  - ntt_agu_top.sv
  - target: test
    files:
      - ntt_agu_assert.sv
      - tb_ntt_agu.sv
